// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths and reset vector
`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_RESET_PC 32'h0000_0000

// ----------------------------------------
// Major opcodes, instr[6:0]
// ----------------------------------------
`define RV_OP_OP     7'b0110011
`define RV_OP_OPIMM  7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_SYSTEM 7'b1110011

// ALU funct3, SUB and SRA share codes with ADD and SRL
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// Branch funct3
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001
`define RV_F3_BLT 3'b100
`define RV_F3_BGE 3'b101

// Word access width, CSR read-set, alternate funct7
`define RV_F3_WORD  3'b010
`define RV_F3_CSRRS 3'b010
`define RV_F7_ALT   7'b0100000

// Full EBREAK encoding
`define RV_INSTR_EBREAK 32'h0010_0073

// Zicntr CSR numbers
`define RV_CSR_CYCLE   12'hC00
`define RV_CSR_INSTRET 12'hC02

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // Architectural value, address or data
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // ----------------------------------------
  // Enums
  // ----------------------------------------

  // Instruction class as seen by the sequencer
  typedef enum logic [3:0] {
    CLS_ALU,
    CLS_LUI,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_CSR,
    CLS_EBREAK,
    CLS_ILLEGAL
  } op_class_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_t;

  // LT and GE are signed
  typedef enum logic [1:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE
  } br_cond_t;

  typedef enum logic {
    CSR_CYCLE,
    CSR_INSTRET
  } csr_sel_t;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEMORY,
    ST_HALTED
  } ctrl_state_t;

  // ----------------------------------------
  // Bus and decode structs
  // ----------------------------------------

  // Request held stable until its response
  typedef struct packed {
    logic  valid;
    logic  we;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    op_class_t op_class;
    alu_op_t   alu_op;
    br_cond_t  br_cond;
    csr_sel_t  csr_sel;
    logic      use_imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
  } decode_t;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

// 32 x 32 register file, x0 reads as zero
module rv_regfile (
  input  logic                 clk,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic                 we,
  input  logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

  // Combinational read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Single write port, x0 writes dropped
  always_ff @(posedge clk) begin
    if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

// Combinational decode of the instruction register
module rv_decode (
  input  rv_pkg::word_t   instr,
  output rv_pkg::decode_t dec
);
  import rv_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] csr_num;

  // Immediates per format
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // ALU op implied by funct3 with funct7 clear
  alu_op_t f3_alu;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign csr_num = instr[31:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (funct3)
      `RV_F3_ADD:  f3_alu = ALU_ADD;
      `RV_F3_SLL:  f3_alu = ALU_SLL;
      `RV_F3_SLT:  f3_alu = ALU_SLT;
      `RV_F3_SLTU: f3_alu = ALU_SLTU;
      `RV_F3_XOR:  f3_alu = ALU_XOR;
      `RV_F3_SRL:  f3_alu = ALU_SRL;
      `RV_F3_OR:   f3_alu = ALU_OR;
      default:     f3_alu = ALU_AND;
    endcase
  end

  // ----------------------------------------
  // Classification, anything not matched is ILLEGAL
  // ----------------------------------------
  always_comb begin
    dec.op_class = CLS_ILLEGAL;
    dec.alu_op   = f3_alu;
    dec.br_cond  = BR_EQ;
    dec.csr_sel  = CSR_CYCLE;
    dec.use_imm  = 1'b0;
    dec.rd       = instr[11:7];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.imm      = imm_i;
    case (opcode)
      `RV_OP_OP: begin
        if (funct7 == 7'b0) begin
          dec.op_class = CLS_ALU;
        end else if (funct7 == `RV_F7_ALT && funct3 == `RV_F3_ADD) begin
          dec.op_class = CLS_ALU;
          dec.alu_op   = ALU_SUB;
        end else if (funct7 == `RV_F7_ALT && funct3 == `RV_F3_SRL) begin
          dec.op_class = CLS_ALU;
          dec.alu_op   = ALU_SRA;
        end
      end
      `RV_OP_OPIMM: begin
        dec.use_imm = 1'b1;
        // Shift immediates carry funct7 in imm[11:5]
        if (funct3 == `RV_F3_SLL) begin
          if (funct7 == 7'b0) dec.op_class = CLS_ALU;
        end else if (funct3 == `RV_F3_SRL) begin
          if (funct7 == 7'b0) dec.op_class = CLS_ALU;
          if (funct7 == `RV_F7_ALT) begin
            dec.op_class = CLS_ALU;
            dec.alu_op   = ALU_SRA;
          end
        end else begin
          dec.op_class = CLS_ALU;
        end
      end
      `RV_OP_LUI: begin
        dec.op_class = CLS_LUI;
        dec.imm      = imm_u;
      end
      // Word accesses only
      `RV_OP_LOAD: begin
        if (funct3 == `RV_F3_WORD) dec.op_class = CLS_LOAD;
      end
      `RV_OP_STORE: begin
        dec.imm = imm_s;
        if (funct3 == `RV_F3_WORD) dec.op_class = CLS_STORE;
      end
      `RV_OP_BRANCH: begin
        dec.imm      = imm_b;
        dec.op_class = CLS_BRANCH;
        case (funct3)
          `RV_F3_BEQ: dec.br_cond = BR_EQ;
          `RV_F3_BNE: dec.br_cond = BR_NE;
          `RV_F3_BLT: dec.br_cond = BR_LT;
          `RV_F3_BGE: dec.br_cond = BR_GE;
          default:    dec.op_class = CLS_ILLEGAL;
        endcase
      end
      `RV_OP_JAL: begin
        dec.op_class = CLS_JAL;
        dec.imm      = imm_j;
      end
      `RV_OP_SYSTEM: begin
        // RDCYCLE and RDINSTRET are CSRRS rd, csr, x0
        if (instr == `RV_INSTR_EBREAK) begin
          dec.op_class = CLS_EBREAK;
        end else if (funct3 == `RV_F3_CSRRS && instr[19:15] == 5'd0) begin
          if (csr_num == `RV_CSR_CYCLE) begin
            dec.op_class = CLS_CSR;
          end else if (csr_num == `RV_CSR_INSTRET) begin
            dec.op_class = CLS_CSR;
            dec.csr_sel  = CSR_INSTRET;
          end
        end
      end
      default: dec.op_class = CLS_ILLEGAL;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

// ALU, branch compare, address generation, writeback select
module rv_execute (
  input  rv_pkg::decode_t dec,
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   load_data,
  input  rv_pkg::word_t   cycle,
  input  rv_pkg::word_t   instret,
  output rv_pkg::word_t   rd_value,
  output rv_pkg::word_t   mem_addr,
  output rv_pkg::word_t   branch_target,
  output logic            branch_taken
);
  import rv_pkg::*;

  word_t op_b;
  word_t alu_result;
  logic  cond_true;

  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_result = rs1_data + op_b;
      ALU_SUB:  alu_result = rs1_data - op_b;
      ALU_AND:  alu_result = rs1_data & op_b;
      ALU_OR:   alu_result = rs1_data | op_b;
      ALU_XOR:  alu_result = rs1_data ^ op_b;
      ALU_SLT:  alu_result = ($signed(rs1_data) < $signed(op_b)) ? word_t'(1) : '0;
      ALU_SLTU: alu_result = (rs1_data < op_b) ? word_t'(1) : '0;
      // Shift amount is the low five bits
      ALU_SLL:  alu_result = rs1_data << op_b[4:0];
      ALU_SRL:  alu_result = rs1_data >> op_b[4:0];
      ALU_SRA:  alu_result = word_t'($signed(rs1_data) >>> op_b[4:0]);
      default:  alu_result = '0;
    endcase
  end

  // Branch compare always on rs1 and rs2
  always_comb begin
    case (dec.br_cond)
      BR_EQ:   cond_true = (rs1_data == rs2_data);
      BR_NE:   cond_true = (rs1_data != rs2_data);
      BR_LT:   cond_true = ($signed(rs1_data) < $signed(rs2_data));
      default: cond_true = ($signed(rs1_data) >= $signed(rs2_data));
    endcase
  end

  assign branch_taken  = (dec.op_class == CLS_JAL) ||
                         ((dec.op_class == CLS_BRANCH) && cond_true);
  assign branch_target = pc + dec.imm;
  assign mem_addr      = rs1_data + dec.imm;

  // Writeback value by class
  always_comb begin
    case (dec.op_class)
      CLS_ALU:  rd_value = alu_result;
      CLS_LUI:  rd_value = dec.imm;
      CLS_JAL:  rd_value = pc + 32'd4;
      CLS_LOAD: rd_value = load_data;
      CLS_CSR:  rd_value = (dec.csr_sel == CSR_CYCLE) ? cycle : instret;
      default:  rd_value = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

// Zicntr cycle and instret, low 32 bits
module rv_counters (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          retire,
  input  logic          halted,
  output rv_pkg::word_t cycle,
  output rv_pkg::word_t instret
);

  // ----------------------------------------
  // Counters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cycle   <= '0;
      instret <= '0;
    end else begin
      // Cycle freezes once the core halts
      if (!halted) begin
        cycle <= cycle + 32'd1;
      end
      // A reader sees the count before its own retire
      if (retire) begin
        instret <= instret + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

// Sequencer: FETCH -> EXECUTE -> (MEMORY) -> FETCH, or HALTED
module rv_control (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::mem_rsp_t imem_rsp,
  input  rv_pkg::mem_rsp_t dmem_rsp,
  input  rv_pkg::decode_t  dec,
  input  logic             branch_taken,
  input  rv_pkg::word_t    branch_target,
  input  rv_pkg::word_t    mem_addr,
  input  rv_pkg::word_t    store_data,
  output rv_pkg::mem_req_t imem_req,
  output rv_pkg::mem_req_t dmem_req,
  output rv_pkg::word_t    instr,
  output rv_pkg::word_t    pc,
  output logic             rf_we,
  output logic             retire,
  output logic             halted,
  output logic             ebreak,
  output logic             trap
);
  import rv_pkg::*;

  ctrl_state_t state;

  // Request valids, registered so they only move on a clock edge
  logic imem_valid;
  logic dmem_valid;

  word_t pc_plus4;
  word_t pc_next;

  logic fetch_done;
  logic mem_done;
  logic is_mem;
  logic is_halt;
  logic writes_rd;

  // ----------------------------------------
  // Decode-derived control
  // ----------------------------------------
  assign is_mem    = (dec.op_class == CLS_LOAD) || (dec.op_class == CLS_STORE);
  assign is_halt   = (dec.op_class == CLS_EBREAK) || (dec.op_class == CLS_ILLEGAL);
  assign writes_rd = (dec.op_class == CLS_ALU) || (dec.op_class == CLS_LUI) ||
                     (dec.op_class == CLS_JAL) || (dec.op_class == CLS_CSR);

  // Response completes the outstanding request
  assign fetch_done = (state == ST_FETCH) && imem_valid && imem_rsp.valid;
  assign mem_done   = (state == ST_MEMORY) && dmem_valid && dmem_rsp.valid;

  // Only branches and JAL ever raise branch_taken
  assign pc_plus4 = pc + 32'd4;
  assign pc_next  = branch_taken ? branch_target : pc_plus4;

  // Non-memory ops write in EXECUTE, a load at its response
  assign rf_we  = ((state == ST_EXECUTE) && writes_rd) ||
                  (mem_done && (dec.op_class == CLS_LOAD));
  assign retire = ((state == ST_EXECUTE) && !is_mem && !is_halt) || mem_done;
  assign halted = (state == ST_HALTED);

  // ----------------------------------------
  // Memory ports
  // ----------------------------------------
  always_comb begin
    imem_req.valid = imem_valid;
    imem_req.we    = 1'b0;
    imem_req.addr  = pc;
    imem_req.wdata = '0;
    // Address and data hold because IR and registers hold in MEMORY
    dmem_req.valid = dmem_valid;
    dmem_req.we    = (dec.op_class == CLS_STORE);
    dmem_req.addr  = mem_addr;
    dmem_req.wdata = store_data;
  end

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_FETCH;
      pc         <= `RV_RESET_PC;
      imem_valid <= 1'b0;
      dmem_valid <= 1'b0;
      ebreak     <= 1'b0;
      trap       <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          // First fetch after reset raises valid here
          if (!imem_valid) begin
            imem_valid <= 1'b1;
          end else if (fetch_done) begin
            imem_valid <= 1'b0;
            state      <= ST_EXECUTE;
          end
        end
        ST_EXECUTE: begin
          if (is_halt) begin
            state  <= ST_HALTED;
            ebreak <= (dec.op_class == CLS_EBREAK);
            trap   <= (dec.op_class == CLS_ILLEGAL);
          end else if (is_mem) begin
            state      <= ST_MEMORY;
            dmem_valid <= 1'b1;
          end else begin
            state      <= ST_FETCH;
            pc         <= pc_next;
            imem_valid <= 1'b1;
          end
        end
        ST_MEMORY: begin
          if (mem_done) begin
            state      <= ST_FETCH;
            pc         <= pc_plus4;
            dmem_valid <= 1'b0;
            imem_valid <= 1'b1;
          end
        end
        // HALTED holds until reset
        default: state <= ST_HALTED;
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (fetch_done) begin
      instr <= imem_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// Multi-cycle RV32I core, one instruction in flight
module rv_core (
  input  logic             clk,
  input  logic             rst_n,
  output rv_pkg::mem_req_t imem_req,
  input  rv_pkg::mem_rsp_t imem_rsp,
  output rv_pkg::mem_req_t dmem_req,
  input  rv_pkg::mem_rsp_t dmem_rsp,
  output logic             ebreak,
  output logic             trap
);
  import rv_pkg::*;

  // Decode of the instruction register
  decode_t dec;
  word_t   instr;
  word_t   pc;

  // Register file read data
  word_t rs1_data;
  word_t rs2_data;

  // Execute results
  word_t rd_value;
  word_t mem_addr;
  word_t branch_target;
  logic  branch_taken;

  // Sequencer strobes
  logic rf_we;
  logic retire;
  logic halted;

  // Zicntr values
  word_t cycle;
  word_t instret;

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  rv_control u_control (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_rsp     (imem_rsp),
    .dmem_rsp     (dmem_rsp),
    .dec          (dec),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .mem_addr     (mem_addr),
    .store_data   (rs2_data),
    .imem_req     (imem_req),
    .dmem_req     (dmem_req),
    .instr        (instr),
    .pc           (pc),
    .rf_we        (rf_we),
    .retire       (retire),
    .halted       (halted),
    .ebreak       (ebreak),
    .trap         (trap)
  );

  rv_decode u_decode (
    .instr(instr),
    .dec  (dec)
  );

  // Write port takes rd straight from decode
  rv_regfile u_regfile (
    .clk     (clk),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rd      (dec.rd),
    .we      (rf_we),
    .wdata   (rd_value),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // Load data comes from the data response in its valid cycle
  rv_execute u_execute (
    .dec          (dec),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .load_data    (dmem_rsp.rdata),
    .cycle        (cycle),
    .instret      (instret),
    .rd_value     (rd_value),
    .mem_addr     (mem_addr),
    .branch_target(branch_target),
    .branch_taken (branch_taken)
  );

  rv_counters u_counters (
    .clk    (clk),
    .rst_n  (rst_n),
    .retire (retire),
    .halted (halted),
    .cycle  (cycle),
    .instret(instret)
  );

endmodule

`default_nettype wire

// ==== testbench/rv_core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol and halt rules of the sequencer
module rv_core_assertions (
  input logic                clk,
  input logic                rst_n,
  input rv_pkg::ctrl_state_t state,
  input rv_pkg::mem_req_t    imem_req,
  input rv_pkg::mem_req_t    dmem_req,
  input rv_pkg::mem_rsp_t    imem_rsp,
  input rv_pkg::mem_rsp_t    dmem_rsp,
  input logic                halted,
  input logic                ebreak,
  input logic                trap
);
  import rv_pkg::*;

  // Number of failed assertions, read by the testbench
  int fail_count = 0;

  // ----------------------------------------
  // Request/response handshake
  // ----------------------------------------

  // Whole request frozen while waiting for its response
  imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req.valid && !imem_rsp.valid |=> $stable(imem_req))
    else begin
      fail_count++;
      $error("imem request changed before its response");
    end

  dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_req.valid && !dmem_rsp.valid |=> $stable(dmem_req))
    else begin
      fail_count++;
      $error("dmem request changed before its response");
    end

  // Data port only used in the memory step
  dmem_in_memory: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_req.valid |-> state == ST_MEMORY)
    else begin
      fail_count++;
      $error("dmem request outside MEMORY");
    end

  // ----------------------------------------
  // Halt behavior
  // ----------------------------------------
  no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !imem_req.valid)
    else begin
      fail_count++;
      $error("fetch issued while halted");
    end

  // Only one halt cause at a time
  one_halt_cause: assert property (@(posedge clk) disable iff (!rst_n)
    !(ebreak && trap))
    else begin
      fail_count++;
      $error("ebreak and trap both set");
    end

endmodule

bind rv_control rv_core_assertions u_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .state   (state),
  .imem_req(imem_req),
  .dmem_req(dmem_req),
  .imem_rsp(imem_rsp),
  .dmem_rsp(dmem_rsp),
  .halted  (halted),
  .ebreak  (ebreak),
  .trap    (trap)
);

`default_nettype wire

// ==== testbench/rv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_tb;
  import rv_pkg::*;

  localparam logic [2:0] NO_REQ = 3'd7;

  logic     clk = 1'b0;
  logic     rst_n = 1'b0;
  mem_req_t imem_req;
  mem_rsp_t imem_rsp = '0;
  mem_req_t dmem_req;
  mem_rsp_t dmem_rsp = '0;
  logic     ebreak;
  logic     trap;

  // Word indexed memory models
  word_t      imem [256];
  word_t      dmem [256];
  logic [7:0] prog_len;

  // Response delay state
  word_t      rng = 32'd1;
  logic [2:0] imem_wait = NO_REQ;
  logic [2:0] dmem_wait = NO_REQ;
  logic [2:0] idly;
  logic [2:0] ddly;

  int errors = 0;
  int base_errors;
  int tests = 0;

  rv_core UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .imem_req(imem_req),
    .imem_rsp(imem_rsp),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp),
    .ebreak  (ebreak),
    .trap    (trap)
  );

  always #50 clk = ~clk;

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Wait states 0 to 3
  function automatic logic [2:0] draw_delay();
    rng = xorshift(rng);
    return {1'b0, rng[1:0]};
  endfunction

  // ----------------------------------------
  // Memory ports answer each request once
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n || imem_rsp.valid) begin
      imem_rsp  <= '0;
      imem_wait <= NO_REQ;
    end else if (imem_req.valid) begin
      idly = (imem_wait == NO_REQ) ? draw_delay() : imem_wait;
      if (idly == 3'd0) begin
        // The instruction port only reads
        check_flag("imem_req.we", imem_req.we, 1'b0);
        imem_rsp.valid <= 1'b1;
        imem_rsp.rdata <= imem[imem_req.addr[9:2]];
      end else begin
        imem_wait <= idly - 3'd1;
      end
    end
    if (!rst_n || dmem_rsp.valid) begin
      dmem_rsp  <= '0;
      dmem_wait <= NO_REQ;
    end else if (dmem_req.valid) begin
      ddly = (dmem_wait == NO_REQ) ? draw_delay() : dmem_wait;
      if (ddly == 3'd0) begin
        // Store data lands with its response
        if (dmem_req.we) begin
          dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
        end
        dmem_rsp.valid <= 1'b1;
        dmem_rsp.rdata <= dmem[dmem_req.addr[9:2]];
      end else begin
        dmem_wait <= ddly - 3'd1;
      end
    end
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------
  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_OP};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  // Word store only
  function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic word_t enc_b(input int imm, input logic [2:0] f3, input int rs1,
                                  input int rs2);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  // LUI
  function automatic word_t enc_u(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], `RV_OP_LUI};
  endfunction

  function automatic word_t enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
  endfunction

  function automatic word_t addi(input int rd, input int rs1, input int imm);
    return enc_i(imm, rs1, `RV_F3_ADD, rd, `RV_OP_OPIMM);
  endfunction

  function automatic word_t lw(input int rd, input int rs1, input int imm);
    return enc_i(imm, rs1, `RV_F3_WORD, rd, `RV_OP_LOAD);
  endfunction

  // CSRRS rd, csr, x0
  function automatic word_t csr_read(input int rd, input logic [11:0] csr);
    return {csr, 5'd0, `RV_F3_CSRRS, rd[4:0], `RV_OP_SYSTEM};
  endfunction

  // Ten R-type ALU ops in the order used by alu_ref
  function automatic word_t alu_instr(input int k, input int rd, input int rs1, input int rs2);
    case (k)
      0: return enc_r(7'b0, rs2, rs1, `RV_F3_ADD, rd);
      1: return enc_r(`RV_F7_ALT, rs2, rs1, `RV_F3_ADD, rd);
      2: return enc_r(7'b0, rs2, rs1, `RV_F3_AND, rd);
      3: return enc_r(7'b0, rs2, rs1, `RV_F3_OR, rd);
      4: return enc_r(7'b0, rs2, rs1, `RV_F3_XOR, rd);
      5: return enc_r(7'b0, rs2, rs1, `RV_F3_SLT, rd);
      6: return enc_r(7'b0, rs2, rs1, `RV_F3_SLTU, rd);
      7: return enc_r(7'b0, rs2, rs1, `RV_F3_SLL, rd);
      8: return enc_r(7'b0, rs2, rs1, `RV_F3_SRL, rd);
      default: return enc_r(`RV_F7_ALT, rs2, rs1, `RV_F3_SRL, rd);
    endcase
  endfunction

  // RV32I results for the same order
  function automatic word_t alu_ref(input int k, input word_t a, input word_t b);
    case (k)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6: return (a < b) ? 32'd1 : 32'd0;
      7: return a << b[4:0];
      8: return a >> b[4:0];
      default: return word_t'($signed(a) >>> b[4:0]);
    endcase
  endfunction

  // ----------------------------------------
  // Program and memory helpers
  // ----------------------------------------
  function automatic word_t fill_word(input int addr);
    return 32'hC0DE_0000 ^ word_t'(addr);
  endfunction

  function automatic word_t dmem_at(input int addr);
    return dmem[addr[9:2]];
  endfunction

  task automatic set_mem(input int addr, input word_t value);
    dmem[addr[9:2]] = value;
  endtask

  task automatic emit(input word_t instr);
    imem[prog_len] = instr;
    prog_len = prog_len + 8'd1;
  endtask

  // Branch skipping one marker store when taken
  task automatic emit_branch(input logic [2:0] f3, input int rs1, input int rs2, input int addr);
    emit(enc_b(8, f3, rs1, rs2));
    emit(enc_s(addr, 9, 0));
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mem(input int addr, input word_t exp);
    check_word($sformatf("dmem[%h]", addr), dmem_at(addr), exp);
  endtask

  task automatic check_halt(input logic exp_ebreak, input logic exp_trap);
    check_flag("ebreak", ebreak, exp_ebreak);
    check_flag("trap", trap, exp_trap);
  endtask

  // ----------------------------------------
  // Test sequencing
  // ----------------------------------------
  task automatic begin_test();
    base_errors = errors;
    prog_len = '0;
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = '0;
      dmem[i[7:0]] = fill_word(i * 4);
    end
  endtask

  // Reset for 4 cycles, then run until a halt output rises
  task automatic run_program();
    int cycles;
    cycles = 0;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    while (!ebreak && !trap && cycles < 4000) begin
      @(posedge clk);
      cycles++;
    end
    if (!ebreak && !trap) begin
      $display("Timeout: the program did not halt within %0d cycles", cycles);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == base_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - base_errors);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_alu();
    word_t a;
    word_t b;
    a = 32'h8000_1234;
    b = 32'h0000_4FF9;
    begin_test();
    emit(enc_u('h80001, 1));
    emit(addi(1, 1, 'h234));
    emit(enc_u('h5, 2));
    emit(addi(2, 2, -7));
    for (int k = 0; k < 10; k++) begin
      emit(alu_instr(k, 10, 1, 2));
      emit(enc_s('h200 + 4 * k, 10, 0));
    end
    // SRAI by 5, SLTI against -1, plain LUI
    emit(enc_i('h405, 1, `RV_F3_SRL, 11, `RV_OP_OPIMM));
    emit(enc_s('h228, 11, 0));
    emit(enc_i(-1, 1, `RV_F3_SLT, 12, `RV_OP_OPIMM));
    emit(enc_s('h22C, 12, 0));
    emit(enc_u('hABCDE, 3));
    emit(enc_s('h230, 3, 0));
    emit(`RV_INSTR_EBREAK);
    run_program();
    for (int k = 0; k < 10; k++) begin
      check_mem('h200 + 4 * k, alu_ref(k, a, b));
    end
    check_mem('h228, word_t'($signed(a) >>> 5));
    check_mem('h22C, 32'd1);
    check_mem('h230, 32'hABCD_E000);
    check_halt(1'b1, 1'b0);
    end_test("alu and lui");
  endtask

  task automatic test_mem();
    word_t v0;
    word_t v1;
    word_t v2;
    v0 = 32'h1234_5678;
    v1 = 32'h0FED_CBA9;
    v2 = 32'hF0F0_1111;
    begin_test();
    set_mem('h100, v0);
    set_mem('h104, v1);
    set_mem('h108, v2);
    emit(lw(1, 0, 'h100));
    emit(lw(2, 0, 'h104));
    emit(lw(3, 0, 'h108));
    emit(enc_r(7'b0, 2, 1, `RV_F3_ADD, 4));
    emit(enc_i(-1, 3, `RV_F3_XOR, 5, `RV_OP_OPIMM));
    emit(addi(6, 0, 'h300));
    emit(enc_s(0, 4, 6));
    emit(enc_s(4, 5, 6));
    emit(enc_s(8, 1, 6));
    // Read back a stored word and modify it
    emit(lw(7, 6, 4));
    emit(addi(7, 7, 1));
    emit(enc_s(12, 7, 6));
    emit(`RV_INSTR_EBREAK);
    run_program();
    check_mem('h300, v0 + v1);
    check_mem('h304, ~v2);
    check_mem('h308, v0);
    check_mem('h30C, ~v2 + 32'd1);
    check_mem('h310, fill_word('h310));
    check_halt(1'b1, 1'b0);
    end_test("loads and stores");
  endtask

  task automatic test_branch();
    logic [15:0] skipped;
    word_t       jal_pc;
    begin_test();
    emit(addi(1, 0, -5));
    emit(addi(2, 0, 3));
    emit(addi(9, 0, 'h5A));
    // Taken cases skip their marker with x1 = -5 and x2 = 3
    emit_branch(`RV_F3_BEQ, 1, 1, 'h380);
    emit_branch(`RV_F3_BEQ, 1, 2, 'h384);
    emit_branch(`RV_F3_BNE, 1, 2, 'h388);
    emit_branch(`RV_F3_BNE, 2, 2, 'h38C);
    emit_branch(`RV_F3_BLT, 1, 2, 'h390);
    emit_branch(`RV_F3_BLT, 2, 1, 'h394);
    emit_branch(`RV_F3_BGE, 2, 1, 'h398);
    emit_branch(`RV_F3_BGE, 1, 2, 'h39C);
    emit_branch(`RV_F3_BGE, 2, 2, 'h3A0);
    skipped = 16'h0155;
    jal_pc = word_t'({prog_len, 2'b00});
    emit(enc_j(8, 5));
    emit(enc_s('h3A4, 9, 0));
    emit(enc_s('h3A8, 5, 0));
    emit(`RV_INSTR_EBREAK);
    run_program();
    for (int k = 0; k < 9; k++) begin
      check_mem('h380 + 4 * k, skipped[k[3:0]] ? fill_word('h380 + 4 * k) : 32'h5A);
    end
    check_mem('h3A4, fill_word('h3A4));
    check_mem('h3A8, jal_pc + 32'd4);
    check_halt(1'b1, 1'b0);
    end_test("branches and jal");
  endtask

  task automatic test_counters();
    begin_test();
    emit(csr_read(1, `RV_CSR_INSTRET));
    emit(addi(3, 0, 1));
    emit(addi(3, 3, 1));
    emit(enc_r(7'b0, 3, 3, `RV_F3_ADD, 4));
    emit(csr_read(2, `RV_CSR_INSTRET));
    emit(csr_read(5, `RV_CSR_CYCLE));
    emit(enc_s('h200, 1, 0));
    emit(enc_s('h204, 2, 0));
    emit(enc_s('h208, 5, 0));
    emit(`RV_INSTR_EBREAK);
    run_program();
    // Instructions retired before each reader
    check_mem('h200, 32'd0);
    check_mem('h204, 32'd4);
    check_flag("cycle >= instret", dmem_at('h208) >= dmem_at('h204), 1'b1);
    check_halt(1'b1, 1'b0);
    end_test("counters");
  endtask

  task automatic test_illegal();
    begin_test();
    emit(addi(1, 0, 'h77));
    emit(enc_s('h240, 1, 0));
    // JALR is not implemented
    emit(enc_i(0, 0, 3'b000, 0, 7'b1100111));
    emit(enc_s('h244, 1, 0));
    emit(`RV_INSTR_EBREAK);
    run_program();
    check_mem('h240, 32'h77);
    check_mem('h244, fill_word('h244));
    check_halt(1'b0, 1'b1);
    end_test("illegal instruction");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    test_alu();
    test_mem();
    test_branch();
    test_counters();
    test_illegal();
    if (UUT.u_control.u_checks.fail_count != 0) begin
      $display("Concurrent assertions failed during the run");
      errors++;
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_counters.sv
hw/rv_control.sv
hw/rv_core.sv
testbench/rv_core_assertions.sv
testbench/rv_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_tb
FILELIST = compile.f
PASS_MSG = PASS: all tests

.PHONY: sim clean

# Build, run, then search the output for the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
